//--- hw/xfcp_ram_pkg.sv
// Command codes, bus widths, decoder states and the Wishbone data word.
`default_nettype none

package xfcp_ram_pkg;

    localparam int BYTE_W = 8;
    localparam int ADDR_W = 8;
    localparam int COUNT_W = 16;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W = 4;
    localparam int WB_ADDR_W = 6;
    localparam int RAM_DEPTH = 64;
    // low address bits that pick the byte lane.
    localparam int LANE_W = $clog2(WB_SEL_W);

    localparam logic [BYTE_W-1:0] CMD_READ_REQ = 8'h10;
    localparam logic [BYTE_W-1:0] CMD_READ_RESP = 8'h11;
    localparam logic [BYTE_W-1:0] CMD_WRITE_REQ = 8'h12;
    localparam logic [BYTE_W-1:0] CMD_WRITE_RESP = 8'h13;

    // one bus word, seen whole by the RAM or per lane by the executor.
    typedef union packed {
        logic [WB_DATA_W-1:0] word;
        logic [WB_SEL_W-1:0][BYTE_W-1:0] lane;
    } wb_word_t;

    typedef enum logic [2:0] {
        RX_CMD,
        RX_ADDR,
        RX_CNT_LO,
        RX_CNT_HI,
        RX_WDATA,
        RX_RDGEN,
        RX_DRAIN
    } rx_state_t;

endpackage

`default_nettype wire

//--- hw/xfcp_op_if.sv
// Byte operation channel from the request decoder to the memory executor.
`default_nettype none

interface xfcp_op_if;

    logic op_valid;
    logic op_ready;
    logic op_we;
    logic [xfcp_ram_pkg::ADDR_W-1:0] op_addr;
    logic [xfcp_ram_pkg::BYTE_W-1:0] op_data;
    // final write of a packet.
    logic op_last;

    modport decoder (
        output op_valid,
        output op_we,
        output op_addr,
        output op_data,
        output op_last,
        input  op_ready
    );

    modport executor (
        input  op_valid,
        input  op_we,
        input  op_addr,
        input  op_data,
        input  op_last,
        output op_ready
    );

endinterface

`default_nettype wire

//--- hw/xfcp_wb_if.sv
// Wishbone bus between the memory executor and the RAM.
`default_nettype none

interface xfcp_wb_if;

    logic [xfcp_ram_pkg::WB_ADDR_W-1:0] adr;
    xfcp_ram_pkg::wb_word_t dat_w;
    xfcp_ram_pkg::wb_word_t dat_r;
    logic we;
    logic [xfcp_ram_pkg::WB_SEL_W-1:0] sel;
    logic stb;
    logic cyc;
    logic ack;

    modport master (
        output adr,
        output dat_w,
        output we,
        output sel,
        output stb,
        output cyc,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  we,
        input  sel,
        input  stb,
        input  cyc,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

//--- hw/xfcp_rx_decode.sv
// Request packet decoder that walks the header and issues byte operations.
`default_nettype none

module xfcp_rx_decode (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic [xfcp_ram_pkg::BYTE_W-1:0]    up_tdata_i,
    input  logic                               up_tvalid_i,
    input  logic                               up_tlast_i,
    output logic                               up_tready_o,
    xfcp_op_if.decoder                         op,
    output logic                               resp_start_o,
    output logic                               resp_is_read_o,
    output logic [xfcp_ram_pkg::COUNT_W-1:0]   resp_count_o
);

    xfcp_ram_pkg::rx_state_t state_q;
    logic run_q;
    logic seen_q;
    logic is_wr_q;
    logic [xfcp_ram_pkg::ADDR_W-1:0] addr_q;
    logic [xfcp_ram_pkg::BYTE_W-1:0] cnt_lo_q;
    logic [xfcp_ram_pkg::COUNT_W-1:0] remain_q;
    logic [xfcp_ram_pkg::COUNT_W-1:0] hdr_count;
    logic up_beat;
    logic op_fire;
    logic known_cmd;
    logic seen_next;

    assign up_beat = up_tvalid_i & up_tready_o;
    assign op_fire = op.op_valid & op.op_ready;
    assign hdr_count = {up_tdata_i, cnt_lo_q};
    assign known_cmd = (up_tdata_i == xfcp_ram_pkg::CMD_READ_REQ) ||
                       (up_tdata_i == xfcp_ram_pkg::CMD_WRITE_REQ);
    // tlast of the request, seen now or earlier while reads are generated.
    assign seen_next = seen_q | (up_beat & up_tlast_i);

    // write payload passes straight through, reads come from the counter.
    assign op.op_valid = ((state_q == xfcp_ram_pkg::RX_WDATA) & up_tvalid_i) |
                         (state_q == xfcp_ram_pkg::RX_RDGEN);
    assign op.op_we = (state_q == xfcp_ram_pkg::RX_WDATA);
    assign op.op_addr = addr_q;
    assign op.op_data = up_tdata_i;
    assign op.op_last = (remain_q == 1) | ((state_q == xfcp_ram_pkg::RX_WDATA) & up_tlast_i);

    always_comb begin
        case (state_q)
            // a new command waits until the memory side is free.
            xfcp_ram_pkg::RX_CMD:   up_tready_o = run_q & op.op_ready;
            xfcp_ram_pkg::RX_WDATA: up_tready_o = op.op_ready;
            xfcp_ram_pkg::RX_RDGEN: up_tready_o = !seen_q;
            default:                up_tready_o = run_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= xfcp_ram_pkg::RX_CMD;
            run_q <= 1'b0;
            seen_q <= 1'b0;
            remain_q <= '0;
            resp_start_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            resp_start_o <= up_beat & (state_q == xfcp_ram_pkg::RX_CNT_HI);
            if (up_beat) begin
                seen_q <= up_tlast_i | (seen_q & (state_q != xfcp_ram_pkg::RX_CNT_HI));
            end
            case (state_q)
                xfcp_ram_pkg::RX_CMD: begin
                    if (up_beat) begin
                        if (up_tlast_i) begin
                            state_q <= xfcp_ram_pkg::RX_CMD;
                        end else if (known_cmd) begin
                            state_q <= xfcp_ram_pkg::RX_ADDR;
                        end else begin
                            state_q <= xfcp_ram_pkg::RX_DRAIN;
                        end
                    end
                end
                xfcp_ram_pkg::RX_ADDR: begin
                    if (up_beat) begin
                        state_q <= up_tlast_i ? xfcp_ram_pkg::RX_CMD : xfcp_ram_pkg::RX_CNT_LO;
                    end
                end
                xfcp_ram_pkg::RX_CNT_LO: begin
                    if (up_beat) begin
                        state_q <= up_tlast_i ? xfcp_ram_pkg::RX_CMD : xfcp_ram_pkg::RX_CNT_HI;
                    end
                end
                xfcp_ram_pkg::RX_CNT_HI: begin
                    if (up_beat) begin
                        remain_q <= hdr_count;
                        if (hdr_count != '0 && !(is_wr_q && up_tlast_i)) begin
                            state_q <= is_wr_q ? xfcp_ram_pkg::RX_WDATA : xfcp_ram_pkg::RX_RDGEN;
                        end else begin
                            state_q <= up_tlast_i ? xfcp_ram_pkg::RX_CMD : xfcp_ram_pkg::RX_DRAIN;
                        end
                    end
                end
                xfcp_ram_pkg::RX_WDATA: begin
                    if (op_fire) begin
                        remain_q <= remain_q - 1'b1;
                        if (op.op_last) begin
                            state_q <= up_tlast_i ? xfcp_ram_pkg::RX_CMD : xfcp_ram_pkg::RX_DRAIN;
                        end
                    end
                end
                xfcp_ram_pkg::RX_RDGEN: begin
                    if (op_fire) begin
                        remain_q <= remain_q - 1'b1;
                        if (op.op_last) begin
                            state_q <= seen_next ? xfcp_ram_pkg::RX_CMD : xfcp_ram_pkg::RX_DRAIN;
                        end
                    end
                end
                xfcp_ram_pkg::RX_DRAIN: begin
                    if (up_beat && up_tlast_i) begin
                        state_q <= xfcp_ram_pkg::RX_CMD;
                    end
                end
                default: state_q <= xfcp_ram_pkg::RX_CMD;
            endcase
        end
    end

    // header fields and response details.
    always_ff @(posedge clk) begin
        if (up_beat) begin
            case (state_q)
                xfcp_ram_pkg::RX_CMD:    is_wr_q <= (up_tdata_i == xfcp_ram_pkg::CMD_WRITE_REQ);
                xfcp_ram_pkg::RX_ADDR:   addr_q <= up_tdata_i;
                xfcp_ram_pkg::RX_CNT_LO: cnt_lo_q <= up_tdata_i;
                xfcp_ram_pkg::RX_CNT_HI: begin
                    resp_is_read_o <= !is_wr_q;
                    // a write cut off right after its header answers at once.
                    resp_count_o <= (is_wr_q && up_tlast_i) ? '0 : hdr_count;
                end
                default: ;
            endcase
        end
        if (op_fire) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/xfcp_mem_exec.sv
// Wishbone master that runs one lane-selected bus cycle per byte operation.
`default_nettype none

module xfcp_mem_exec (
    input  logic                              clk,
    input  logic                              rst_n_i,
    xfcp_op_if.executor                       op,
    xfcp_wb_if.master                         wb,
    output logic                              rd_valid_o,
    output logic [xfcp_ram_pkg::BYTE_W-1:0]   rd_data_o,
    input  logic                              rd_ready_i,
    output logic                              write_done_o
);

    logic [xfcp_ram_pkg::LANE_W-1:0] lane;
    logic [xfcp_ram_pkg::LANE_W-1:0] lane_q;
    logic last_q;
    logic op_fire;
    logic ack_seen;

    // only one bus cycle and one held read byte at a time.
    assign op.op_ready = !wb.cyc & !rd_valid_o & rd_ready_i;
    assign op_fire = op.op_valid & op.op_ready;
    assign ack_seen = wb.cyc & wb.ack;
    assign lane = op.op_addr[xfcp_ram_pkg::LANE_W-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.stb <= 1'b0;
            wb.cyc <= 1'b0;
            last_q <= 1'b0;
            rd_valid_o <= 1'b0;
            write_done_o <= 1'b0;
        end else begin
            if (op_fire) begin
                wb.stb <= 1'b1;
                wb.cyc <= 1'b1;
                last_q <= op.op_we & op.op_last;
            end else if (ack_seen) begin
                wb.stb <= 1'b0;
                wb.cyc <= 1'b0;
            end
            write_done_o <= ack_seen & wb.we & last_q;
            if (ack_seen && !wb.we) begin
                rd_valid_o <= 1'b1;
            end else if (rd_ready_i) begin
                rd_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            wb.adr <= op.op_addr[xfcp_ram_pkg::ADDR_W-1:xfcp_ram_pkg::LANE_W];
            wb.we <= op.op_we;
            wb.sel <= '0;
            wb.sel[lane] <= 1'b1;
            // other lanes are masked off by sel.
            wb.dat_w.lane[lane] <= op.op_data;
            lane_q <= lane;
        end
        if (ack_seen && !wb.we) begin
            rd_data_o <= wb.dat_r.lane[lane_q];
        end
    end

endmodule

`default_nettype wire

//--- hw/xfcp_wb_ram.sv
// Wishbone RAM of 64 words with byte lane enables and a registered ack.
`default_nettype none

module xfcp_wb_ram (
    input  logic        clk,
    input  logic        rst_n_i,
    xfcp_wb_if.slave    wb
);

    xfcp_ram_pkg::wb_word_t mem [xfcp_ram_pkg::RAM_DEPTH];
    logic access;

    // a new request, not the one already being acknowledged.
    assign access = wb.cyc & wb.stb & !wb.ack;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
            for (int i = 0; i < xfcp_ram_pkg::RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            wb.ack <= access;
            if (access && wb.we) begin
                for (int l = 0; l < xfcp_ram_pkg::WB_SEL_W; l++) begin
                    if (wb.sel[l]) begin
                        mem[wb.adr].lane[l] <= wb.dat_w.lane[l];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb.dat_r <= mem[wb.adr];
        end
    end

endmodule

`default_nettype wire

//--- hw/xfcp_tx_result.sv
// Response packet builder with a one-byte output register.
`default_nettype none

module xfcp_tx_result (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               resp_start_i,
    input  logic                               resp_is_read_i,
    input  logic [xfcp_ram_pkg::COUNT_W-1:0]   resp_count_i,
    input  logic                               rd_valid_i,
    input  logic [xfcp_ram_pkg::BYTE_W-1:0]    rd_data_i,
    output logic                               rd_ready_o,
    input  logic                               write_done_i,
    output logic [xfcp_ram_pkg::BYTE_W-1:0]    down_tdata_o,
    output logic                               down_tvalid_o,
    input  logic                               down_tready_i,
    output logic                               down_tlast_o
);

    logic act_q;
    logic act_rd_q;
    logic pend_q;
    logic pend_rd_q;
    logic [xfcp_ram_pkg::COUNT_W-1:0] pend_cnt_q;
    logic [xfcp_ram_pkg::COUNT_W-1:0] remain_q;
    logic [xfcp_ram_pkg::COUNT_W-1:0] ld_count;
    logic ld_read;
    logic out_free;
    logic load;
    logic rd_take;
    logic wr_fire;

    assign out_free = !down_tvalid_o | down_tready_i;
    // a start that arrives while the last byte is still stalled waits in pend.
    assign load = !act_q & out_free & (pend_q | resp_start_i);
    assign ld_read = pend_q ? pend_rd_q : resp_is_read_i;
    assign ld_count = pend_q ? pend_cnt_q : resp_count_i;
    assign rd_take = act_q & act_rd_q & rd_valid_i & out_free;
    assign wr_fire = act_q & !act_rd_q & write_done_i;
    // low while a finished response drains, which holds back the executor.
    assign rd_ready_o = act_q ? (!act_rd_q | out_free) : !down_tvalid_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            down_tvalid_o <= 1'b0;
            down_tlast_o <= 1'b0;
            act_q <= 1'b0;
            act_rd_q <= 1'b0;
            pend_q <= 1'b0;
            remain_q <= '0;
        end else begin
            if (load) begin
                pend_q <= 1'b0;
            end else if (resp_start_i) begin
                pend_q <= 1'b1;
            end
            if (load) begin
                act_q <= (ld_count != '0);
                act_rd_q <= ld_read;
                remain_q <= ld_count;
                // writes with data answer only once the last write is done.
                down_tvalid_o <= ld_read | (ld_count == '0);
                down_tlast_o <= (ld_count == '0);
            end else if (rd_take) begin
                down_tvalid_o <= 1'b1;
                down_tlast_o <= (remain_q == 1);
                remain_q <= remain_q - 1'b1;
                act_q <= (remain_q != 1);
            end else if (wr_fire) begin
                down_tvalid_o <= 1'b1;
                down_tlast_o <= 1'b1;
                act_q <= 1'b0;
            end else if (down_tready_i) begin
                down_tvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_start_i) begin
            pend_rd_q <= resp_is_read_i;
            pend_cnt_q <= resp_count_i;
        end
        if (load) begin
            down_tdata_o <= ld_read ? xfcp_ram_pkg::CMD_READ_RESP : xfcp_ram_pkg::CMD_WRITE_RESP;
        end else if (rd_take) begin
            down_tdata_o <= rd_data_i;
        end else if (wr_fire) begin
            down_tdata_o <= xfcp_ram_pkg::CMD_WRITE_RESP;
        end
    end

endmodule

`default_nettype wire

//--- hw/xfcp_ram_top.sv
// Top level joining the decoder, executor, RAM and response builder.
`default_nettype none

module xfcp_ram_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic [xfcp_ram_pkg::BYTE_W-1:0]   up_tdata_i,
    input  logic                              up_tvalid_i,
    output logic                              up_tready_o,
    input  logic                              up_tlast_i,
    output logic [xfcp_ram_pkg::BYTE_W-1:0]   down_tdata_o,
    output logic                              down_tvalid_o,
    input  logic                              down_tready_i,
    output logic                              down_tlast_o
);

    logic resp_start;
    logic resp_is_read;
    logic [xfcp_ram_pkg::COUNT_W-1:0] resp_count;
    logic rd_valid;
    logic rd_ready;
    logic [xfcp_ram_pkg::BYTE_W-1:0] rd_data;
    logic write_done;

    xfcp_op_if op_bus ();
    xfcp_wb_if wb_bus ();

    xfcp_rx_decode i_xfcp_rx_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .up_tdata_i     (up_tdata_i),
        .up_tvalid_i    (up_tvalid_i),
        .up_tlast_i     (up_tlast_i),
        .up_tready_o    (up_tready_o),
        .op             (op_bus),
        .resp_start_o   (resp_start),
        .resp_is_read_o (resp_is_read),
        .resp_count_o   (resp_count)
    );

    xfcp_mem_exec i_xfcp_mem_exec (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op           (op_bus),
        .wb           (wb_bus),
        .rd_valid_o   (rd_valid),
        .rd_data_o    (rd_data),
        .rd_ready_i   (rd_ready),
        .write_done_o (write_done)
    );

    xfcp_wb_ram i_xfcp_wb_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb      (wb_bus)
    );

    xfcp_tx_result i_xfcp_tx_result (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .resp_start_i   (resp_start),
        .resp_is_read_i (resp_is_read),
        .resp_count_i   (resp_count),
        .rd_valid_i     (rd_valid),
        .rd_data_i      (rd_data),
        .rd_ready_o     (rd_ready),
        .write_done_i   (write_done),
        .down_tdata_o   (down_tdata_o),
        .down_tvalid_o  (down_tvalid_o),
        .down_tready_i  (down_tready_i),
        .down_tlast_o   (down_tlast_o)
    );

endmodule

`default_nettype wire

//--- bench/xfcp_ram_asserts.sv
// Concurrent checks on the top-level request and response stream ports.
`default_nettype none

module xfcp_ram_asserts (
    input logic       clk,
    input logic       rst_n_i,
    input logic       up_tready_o,
    input logic [7:0] down_tdata_o,
    input logic       down_tvalid_o,
    input logic       down_tready_i,
    input logic       down_tlast_o
);

    // number of failed assertions.
    int fail_count = 0;

    // a stalled beat keeps valid, data and last until it is taken.
    property stall_hold_p;
        @(posedge clk) disable iff (!rst_n_i)
            (down_tvalid_o && !down_tready_i) |=>
                (down_tvalid_o && $stable(down_tdata_o) && $stable(down_tlast_o));
    endproperty

    property down_idle_in_reset_p;
        @(posedge clk) !rst_n_i |-> !down_tvalid_o;
    endproperty

    property up_closed_in_reset_p;
        @(posedge clk) !rst_n_i |-> !up_tready_o;
    endproperty

    stall_hold_a: assert property (stall_hold_p) else begin
        fail_count++;
        $error("response beat changed while stalled");
    end

    down_idle_in_reset_a: assert property (down_idle_in_reset_p) else begin
        fail_count++;
        $error("down_tvalid_o high during reset");
    end

    up_closed_in_reset_a: assert property (up_closed_in_reset_p) else begin
        fail_count++;
        $error("up_tready_o high during reset");
    end

endmodule

bind xfcp_ram_top xfcp_ram_asserts i_xfcp_ram_asserts (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .up_tready_o   (up_tready_o),
    .down_tdata_o  (down_tdata_o),
    .down_tvalid_o (down_tvalid_o),
    .down_tready_i (down_tready_i),
    .down_tlast_o  (down_tlast_o)
);

`default_nettype wire

//--- bench/xfcp_ram_tb.sv
// Testbench for the request and response byte streams of the RAM access path.
`default_nettype none

module xfcp_ram_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_ENTRIES = 256;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int QUIET_CYCLES = 40;
    localparam logic [31:0] SEED = 32'h6e87_71a8;
    localparam string DATA_FILE = "bench/xfcp_ram_testdata.txt";
    // entry kinds in the data file.
    localparam logic [3:0] KIND_IN = 4'h0;
    localparam logic [3:0] KIND_OUT = 4'h1;
    localparam logic [3:0] KIND_END = 4'h2;

    logic clk;
    logic rst_n_i;
    logic [7:0] up_tdata_i;
    logic up_tvalid_i;
    logic up_tready_o;
    logic up_tlast_i;
    logic [7:0] down_tdata_o;
    logic down_tvalid_o;
    logic down_tready_i;
    logic down_tlast_o;

    logic [15:0] testdata [MAX_ENTRIES];
    logic [7:0] in_data [$];
    logic in_last [$];
    logic [7:0] exp_data [$];
    logic exp_last [$];
    int n_entries;
    int error_count;
    int beat_count;
    int cycle_count;
    int timeout_limit;
    integer gap_seed;
    integer stall_seed;

    xfcp_ram_top i_xfcp_ram_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .up_tdata_i    (up_tdata_i),
        .up_tvalid_i   (up_tvalid_i),
        .up_tready_o   (up_tready_o),
        .up_tlast_i    (up_tlast_i),
        .down_tdata_o  (down_tdata_o),
        .down_tvalid_o (down_tvalid_o),
        .down_tready_i (down_tready_i),
        .down_tlast_o  (down_tlast_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // splits the data file into request bytes and expected response bytes.
    task automatic load_testdata();
        logic [3:0] kind;
        $readmemh(DATA_FILE, testdata);
        for (int idx = 0; idx < MAX_ENTRIES; idx++) begin
            kind = testdata[idx][15:12];
            if (kind === KIND_END) begin
                break;
            end else if (kind === KIND_IN) begin
                in_data.push_back(testdata[idx][7:0]);
                in_last.push_back(testdata[idx][8]);
            end else if (kind === KIND_OUT) begin
                exp_data.push_back(testdata[idx][7:0]);
                exp_last.push_back(testdata[idx][8]);
            end else begin
                error_count++;
                $display("data file entry %0d has an unknown kind", idx);
                break;
            end
            n_entries++;
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        if (got !== want) begin
            error_count++;
            $display("error: %s is 0x%02h, expected 0x%02h at output byte %0d",
                     name, got, want, beat_count);
        end
    endtask

    task automatic check_beat();
        logic [7:0] want_data;
        logic want_last;
        if (exp_data.size() == 0) begin
            error_count++;
            $display("output byte 0x%02h arrived after all expected bytes", down_tdata_o);
        end else begin
            want_data = exp_data.pop_front();
            want_last = exp_last.pop_front();
            check_value("down_tdata_o", down_tdata_o, want_data);
            check_value("down_tlast_o", {7'b0, down_tlast_o}, {7'b0, want_last});
            beat_count++;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $random(gap_seed) & 3;
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // the beat moves on the next rising edge once ready is seen high.
    task automatic send_byte(input logic [7:0] data, input logic last);
        up_tdata_i = data;
        up_tlast_i = last;
        up_tvalid_i = 1'b1;
        @(negedge clk);
        while (!up_tready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        up_tvalid_i = 1'b0;
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = i_xfcp_ram_top.i_xfcp_ram_asserts.fail_count;
        $display("run complete: %0d output bytes checked, %0d errors, %0d assertion failures",
                 beat_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // output stalls on random cycles.
    initial begin
        down_tready_i = 1'b0;
        stall_seed = SEED;
        @(posedge rst_n_i);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            down_tready_i = ($random(stall_seed) & 3) != 0;
        end
    end

    always @(negedge clk) begin
        if (rst_n_i && down_tvalid_o && down_tready_i) begin
            check_beat();
        end
    end

    // ends the run when the responses stop coming.
    initial begin
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout after %0d cycles with %0d response bytes still outstanding",
                 cycle_count, exp_data.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        up_tdata_i = '0;
        up_tvalid_i = 1'b0;
        up_tlast_i = 1'b0;
        n_entries = 0;
        error_count = 0;
        beat_count = 0;
        cycle_count = 0;
        timeout_limit = 0;
        gap_seed = SEED;
        load_testdata();
        if (n_entries == 0) begin
            error_count++;
            $display("the test data file could not be read or holds no entries");
        end else begin
            timeout_limit = CYCLES_PER_ENTRY * n_entries;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n_i = 1'b1;
            while (in_data.size() > 0) begin
                idle_gap();
                send_byte(in_data.pop_front(), in_last.pop_front());
            end
            while (exp_data.size() > 0) begin
                @(posedge clk);
            end
            // stray bytes after the last response still get caught.
            repeat (QUIET_CYCLES) @(posedge clk);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- bench/xfcp_ram_testdata.txt
// columns of each entry: kind (0 request byte, 1 expected response byte, 2 end),
// tlast flag, then the byte value in two hex digits
// read 4 bytes from 0x00 after reset
0010 0000 0004 0100
1011 1000 1000 1000 1100
// write 6 bytes at 0x05
0012 0005 0006 0000
00a1 00b2 00c3 00d4 00e5 01f6
1113
// read 8 bytes from 0x04 across the word boundary
0010 0004 0008 0100
1011 1000 10a1 10b2 10c3 10d4 10e5 10f6 1100
// write 3 bytes at 0xfe, wrapping to 0x00
0012 00fe 0003 0000
0031 0042 0153
1113
0010 00fe 0003 0100
1011 1031 1042 1153
// unknown command, then a header cut off after its address
0055 0001 0002 0100
0010 0107
// the next read answers normally
0010 0000 0002 0100
1011 1053 1100
// write declares 4 bytes but ends after 2
0012 0020 0004 0000
0077 0188
1113
0010 0020 0004 0100
1011 1077 1088 1000 1100
// read with count zero
0010 0030 0000 0100
1111
// end of data
2000

//--- xfcp_ram_top.f
hw/xfcp_ram_pkg.sv
hw/xfcp_op_if.sv
hw/xfcp_wb_if.sv
hw/xfcp_rx_decode.sv
hw/xfcp_mem_exec.sv
hw/xfcp_wb_ram.sv
hw/xfcp_tx_result.sv
hw/xfcp_ram_top.sv
bench/xfcp_ram_asserts.sv
bench/xfcp_ram_tb.sv

//--- Makefile
# Verilator build and run of the RAM access testbench.

VERILATOR ?= verilator
TOP       ?= xfcp_ram_tb
FILELIST  ?= xfcp_ram_top.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Verification passed" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
